// File: huff_tree.f
rtl/huff_pkg.sv
rtl/huff_node_sram.sv
rtl/huff_sram_arb.sv
rtl/huff_flv.sv
rtl/huff_htree.sv
rtl/huff_ctrl.sv
rtl/huff_top.sv
verification/huff_props.sv
verification/huff_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 --top-module huff_tb \
       -f huff_tree.f -o huff_sim \
  && ./obj_dir/huff_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/huff_tb.sv
`timescale 1ns/1ps

module huff_tb import huff_pkg::*; ();

  localparam int num_leaves = 64;
  localparam int depth      = 128;
  // Six runs of up to 64 rounds, plus clear, load and readback traffic
  localparam int max_cycles = 6 * (64 * (depth + 20) + 8 * depth) + 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        start;
  mem_req_t    host_req;
  logic        host_grant;
  logic        host_rd_finished;
  node_t       host_rdata;
  logic        busy;
  logic        run_done;
  node_id_t    root;
  logic [6:0]  node_count;

  int          errors      = 0;
  int          tests_run   = 0;
  int          cycle_count = 0;
  int          done_events = 0; // done pulses seen so far
  int          done_mark   = 0; // Count when the current run started
  node_id_t    done_root;       // root and node_count captured at done
  logic [6:0]  done_nodes;
  logic [31:0] lcg_state   = 32'h84a98e81;
  node_t       image [depth];   // Memory contents read back after a run
  logic [45:0] leaf_f [num_leaves]; // Loaded leaf freqs for the model
  int          leaf_n;
  logic [63:0] total;           // Sum of loaded leaf freqs

  huff_top #(
    .num_leaves (num_leaves),
    .depth      (depth)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .host_req         (host_req),
    .host_grant       (host_grant),
    .host_rd_finished (host_rd_finished),
    .host_rdata       (host_rdata),
    .busy             (busy),
    .done             (run_done),
    .root             (root),
    .node_count       (node_count)
  );

  bind huff_sram_arb huff_props u_arb_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .ht_grant   (ht_grant),
    .flv_grant  (flv_grant),
    .host_grant (host_grant),
    .done       (1'b0),
    .find_en    (1'b0),
    .build_en   (1'b0)
  );

  bind huff_ctrl huff_props u_ctrl_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .ht_grant   (1'b0),
    .flv_grant  (1'b0),
    .host_grant (1'b0),
    .done       (done),
    .find_en    (find_en),
    .build_en   (build_en)
  );

  always #10 clk = ~clk; // 20 ns period

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == max_cycles) begin
      $display("Timeout after %0d cycles, a run or host access never finished", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // Catch the done pulse mid-cycle where outputs are stable
  always @(negedge clk) begin
    if (run_done) begin
      done_events <= done_events + 1;
      done_root   <= root;
      done_nodes  <= node_count;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Greedy merge of the two smallest where the cost sums all merged freqs
  function automatic logic [63:0] merge_cost();
    logic [63:0] pool [num_leaves];
    logic [63:0] pick [2];
    logic [63:0] cost;
    int          m;
    int          lo;
    cost = '0;
    m    = leaf_n;
    for (int i = 0; i < leaf_n; i++) begin
      pool[i] = 64'(leaf_f[i]);
    end
    while (m > 1) begin
      for (int p = 0; p < 2; p++) begin
        lo = 0;
        for (int i = 1; i < m; i++) begin
          if (pool[i] < pool[lo]) lo = i;
        end
        pick[p]  = pool[lo];
        pool[lo] = pool[m - 1]; // Fill the hole from the end
        m--;
      end
      cost    += pick[0] + pick[1];
      pool[m] = pick[0] + pick[1];
      m++;
    end
    return cost;
  endfunction

  task automatic report_mismatch(input string name, input logic [95:0] got,
                                 input logic [95:0] exp);
    errors++;
    $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic await_host_grant();
    @(negedge clk);
    while (!host_grant) @(negedge clk);
    @(posedge clk); // Access happens at this edge
    #1;
  endtask

  task automatic host_write(input logic [6:0] addr, input node_t data);
    host_req = '{req: 1'b1, op: op_write, addr: addr, wdata: data};
    await_host_grant();
    host_req = '0;
  endtask

  task automatic host_read(input logic [6:0] addr, output node_t data);
    host_req = '{req: 1'b1, op: op_read, addr: addr, wdata: '0};
    await_host_grant();
    host_req = '0;
    @(negedge clk);
    if (!host_rd_finished) begin
      errors++;
      $display("Host read of address %0d returned no finished strobe", addr);
    end
    data = host_rdata;
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b0;
  endtask

  // Reset clears node_count and host writes fill the memory with inactive nodes
  task automatic fresh_start();
    apply_reset();
    for (int a = 0; a < depth; a++) begin
      host_write(7'(a), '{active: 1'b0, left: null_id, right: null_id, freq: 46'(a) + 46'd1});
    end
    leaf_n = 0;
    total  = '0;
  endtask

  task automatic place_leaf(input logic [6:0] addr, input logic [45:0] freq);
    node_t leaf;
    leaf = '{active: 1'b1, left: null_id, right: null_id, freq: freq};
    host_write(addr, leaf);
    leaf_f[leaf_n] = freq;
    leaf_n++;
    total += 64'(freq);
  endtask

  task automatic place_random_leaves(input int n, input int stride, input int range);
    logic [45:0] f;
    for (int i = 0; i < n; i++) begin
      f = 46'((lcg_next() >> 8) % 32'(range)) + 46'd1; // Never zero
      place_leaf(7'(i * stride), f);
    end
  endtask

  task automatic start_run();
    done_mark = done_events;
    start     = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    while (done_events == done_mark) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic read_image();
    for (int a = 0; a < depth; a++) host_read(7'(a), image[a]);
  endtask

  task automatic single_leaf_tree();
    node_id_t exp_root;
    tests_run++;
    exp_root = '{is_sum: 1'b0, idx: 8'd17}; // Leaf id is its address
    fresh_start();
    place_leaf(7'd17, 46'd77);
    start_run();
    wait_done();
    if (done_root != exp_root) report_mismatch("root", 96'(done_root), 96'(exp_root));
    if (done_nodes != 7'd0) report_mismatch("node_count", 96'(done_nodes), 96'd0);
  endtask

  task automatic two_leaf_tree();
    node_t       top_node;
    node_id_t    exp_left;
    node_id_t    exp_right;
    node_id_t    exp_root;
    logic [45:0] fa;
    logic [45:0] fb;
    tests_run++;
    fa = 46'd900;
    fb = 46'd300;
    fresh_start();
    place_leaf(7'd5, fa);
    place_leaf(7'd40, fb);
    if (fa < fb) begin // Lower frequency goes left
      exp_left  = '{is_sum: 1'b0, idx: 8'd5};
      exp_right = '{is_sum: 1'b0, idx: 8'd40};
    end else begin
      exp_left  = '{is_sum: 1'b0, idx: 8'd40};
      exp_right = '{is_sum: 1'b0, idx: 8'd5};
    end
    exp_root = '{is_sum: 1'b1, idx: 8'(sum_base)};
    start_run();
    wait_done();
    read_image();
    top_node = image[sum_base];
    if (top_node.left != exp_left) report_mismatch("left", 96'(top_node.left), 96'(exp_left));
    if (top_node.right != exp_right)
      report_mismatch("right", 96'(top_node.right), 96'(exp_right));
    if (64'(top_node.freq) != 64'(fa) + 64'(fb))
      report_mismatch("sum freq", 96'(top_node.freq), 96'(fa) + 96'(fb));
    if (!top_node.active) report_mismatch("sum active", 96'(top_node.active), 96'd1);
    if (image[5].active) report_mismatch("leaf 5 active", 96'(image[5].active), 96'd0);
    if (image[40].active) report_mismatch("leaf 40 active", 96'(image[40].active), 96'd0);
    if (done_root != exp_root) report_mismatch("root", 96'(done_root), 96'(exp_root));
    if (done_nodes != 7'd1) report_mismatch("node_count", 96'(done_nodes), 96'd1);
  endtask

  task automatic random_tree_sums();
    node_t       node;
    logic [63:0] child_sum;
    int          active_cnt;
    tests_run++;
    fresh_start();
    place_random_leaves(20, 3, 5000);
    start_run();
    wait_done();
    read_image();
    if (done_nodes != 7'd19) report_mismatch("node_count", 96'(done_nodes), 96'd19);
    if (64'(image[done_root.idx[6:0]].freq) != total)
      report_mismatch("root freq", 96'(image[done_root.idx[6:0]].freq), 96'(total));
    for (int k = 0; k < int'(done_nodes); k++) begin
      node      = image[sum_base + k];
      child_sum = 64'(image[node.left.idx[6:0]].freq) + 64'(image[node.right.idx[6:0]].freq);
      if (64'(node.freq) != child_sum)
        report_mismatch($sformatf("freq[%0d]", sum_base + k), 96'(node.freq), 96'(child_sum));
    end
    active_cnt = 0;
    for (int a = 0; a < depth; a++) begin
      if (image[a].active) active_cnt++;
    end
    if (active_cnt != 1) report_mismatch("active nodes", 96'(active_cnt), 96'd1);
    if (!image[done_root.idx[6:0]].active) begin
      errors++;
      $display("Root node at address %0d was read back inactive", done_root.idx);
    end
  endtask

  task automatic optimal_merge_cost();
    logic [63:0] cost;
    logic [63:0] exp_cost;
    tests_run++;
    fresh_start();
    place_random_leaves(30, 2, 40); // Narrow range gives plenty of ties
    start_run();
    wait_done();
    read_image();
    exp_cost = merge_cost();
    cost     = '0;
    for (int k = 0; k < int'(done_nodes); k++) cost += 64'(image[sum_base + k].freq);
    if (cost != exp_cost) report_mismatch("merge cost", 96'(cost), 96'(exp_cost));
    if (done_nodes != 7'd29) report_mismatch("node_count", 96'(done_nodes), 96'd29);
  endtask

  task automatic empty_tree();
    tests_run++;
    fresh_start();
    start_run();
    wait_done();
    if (done_root != null_id) report_mismatch("root", 96'(done_root), 96'(null_id));
    if (done_nodes != 7'd0) report_mismatch("node_count", 96'(done_nodes), 96'd0);
  endtask

  task automatic host_read_while_busy();
    node_t marker;
    node_t got;
    tests_run++;
    marker = '{active: 1'b0, left: '{is_sum: 1'b0, idx: 8'h2a}, right: null_id,
               freq: 46'h1234_5678};
    fresh_start();
    for (int i = 0; i < 8; i++) place_leaf(7'(i), 46'(i + 1));
    host_write(7'd63, marker); // Inactive and never touched by the tree
    start_run();
    repeat (3) @(posedge clk); // Finder now outranks the host for the whole scan
    #1;
    if (!busy) begin
      errors++;
      $display("DUT was not busy when the host read was issued");
    end
    host_read(7'd63, got);
    if (got != marker) report_mismatch("host_rdata", 96'(got), 96'(marker));
    wait_done();
    if (done_nodes != 7'd7) report_mismatch("node_count", 96'(done_nodes), 96'd7);
  endtask

  initial begin
    rst_n    = 1'b1;
    start    = 1'b0;
    host_req = '0;
    apply_reset();
    single_leaf_tree();
    two_leaf_tree();
    random_tree_sums();
    optimal_merge_cost();
    empty_tree();
    host_read_while_busy();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verification/huff_props.sv
`timescale 1ns/1ps

module huff_props (
  input logic clk,
  input logic rst_n,
  input logic ht_grant,
  input logic flv_grant,
  input logic host_grant,
  input logic done,
  input logic find_en,
  input logic build_en
);

  // Single-port memory, one winner per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (rst_n)
    $onehot0({ht_grant, flv_grant, host_grant}))
    else $error("Arbiter granted more than one requester in a cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // Scan and build phases never overlap
  a_phase_excl: assert property (@(posedge clk) disable iff (rst_n) !(find_en && build_en))
    else $error("find_en and build_en high together");

endmodule

// File: rtl/huff_top.sv
`timescale 1ns/1ps

module huff_top import huff_pkg::*; #(
  parameter int num_leaves = 64,
  parameter int depth      = 128
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  mem_req_t   host_req,         // Host load and readback port
  output logic       host_grant,
  output logic       host_rd_finished,
  output node_t      host_rdata,       // Valid with host_rd_finished
  output logic       busy,
  output logic       done,
  output node_id_t   root,
  output logic [6:0] node_count
);

  mem_req_t    ht_req;
  mem_req_t    flv_req;
  mem_req_t    mem_req;     // Arbitrated request into the memory
  node_t       rdata;       // Shared read data for every peer
  logic        ht_grant;
  logic        flv_grant;
  logic        ht_rd_finished;
  logic        flv_rd_finished;
  logic        find_en;
  logic        build_en;
  logic        flv_done;
  logic        ht_fin;
  node_id_t    least1;
  node_id_t    least2;
  logic [45:0] sum;

  assign host_rdata = rdata; // Host samples it only on its own strobe

  huff_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .flv_done (flv_done),
    .ht_fin   (ht_fin),
    .least1   (least1),
    .least2   (least2),
    .find_en  (find_en),
    .build_en (build_en),
    .busy     (busy),
    .done     (done),
    .root     (root)
  );

  huff_flv #(
    .num_leaves (num_leaves),
    .depth      (depth)
  ) u_flv (
    .clk         (clk),
    .rst_n       (rst_n),
    .find_en     (find_en),
    .mem_req     (flv_req),
    .grant       (flv_grant),
    .rd_finished (flv_rd_finished),
    .rdata       (rdata),
    .least1      (least1),
    .least2      (least2),
    .sum         (sum),
    .flv_done    (flv_done)
  );

  huff_htree u_htree (
    .clk         (clk),
    .rst_n       (rst_n),
    .build_en    (build_en),
    .least1      (least1),
    .least2      (least2),
    .sum         (sum),
    .mem_req     (ht_req),
    .grant       (ht_grant),
    .rd_finished (ht_rd_finished),
    .rdata       (rdata),
    .ht_fin      (ht_fin),
    .node_count  (node_count)
  );

  huff_sram_arb u_arb (
    .clk              (clk),
    .rst_n            (rst_n),
    .ht_req           (ht_req),
    .flv_req          (flv_req),
    .host_req         (host_req),
    .mem_req          (mem_req),
    .ht_grant         (ht_grant),
    .flv_grant        (flv_grant),
    .host_grant       (host_grant),
    .ht_rd_finished   (ht_rd_finished),
    .flv_rd_finished  (flv_rd_finished),
    .host_rd_finished (host_rd_finished)
  );

  huff_node_sram #(
    .depth (depth)
  ) u_sram (
    .clk   (clk),
    .req   (mem_req),
    .rdata (rdata)
  );

endmodule

// File: rtl/huff_ctrl.sv
`timescale 1ns/1ps

module huff_ctrl import huff_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,    // Ignored while a run is in progress
  input  logic     flv_done,
  input  logic     ht_fin,
  input  node_id_t least1,
  input  node_id_t least2,
  output logic     find_en,
  output logic     build_en,
  output logic     busy,
  output logic     done,     // One-cycle end of run
  output node_id_t root      // Valid from done until the next done
);

  ctrl_state_t state;

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      state <= idle;
      root  <= null_id;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= find;
          end
        end
        find: begin
          if (flv_done) begin
            // Fewer than two active nodes, so the tree is finished
            if (least2 == null_id) begin
              state <= huff_pkg::done;
              root  <= least1; // null_id for an empty tree
            end else begin
              state <= build;
            end
          end
        end
        build: begin
          if (ht_fin) begin
            state <= find; // Next round rescans the memory
          end
        end
        default: begin
          state <= idle; // End-of-run cycle
        end
      endcase
    end
  end

  // Phase levels decode straight from the state
  assign find_en  = (state == find);
  assign build_en = (state == build);
  assign busy     = (state != idle);
  assign done     = (state == huff_pkg::done);

endmodule

// File: rtl/huff_htree.sv
`timescale 1ns/1ps

module huff_htree import huff_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        build_en,   // Level from controller, low resets the round
  input  node_id_t    least1,     // Held by the finder for the whole round
  input  node_id_t    least2,
  input  logic [45:0] sum,
  output mem_req_t    mem_req,
  input  logic        grant,
  input  logic        rd_finished,
  input  node_t       rdata,
  output logic        ht_fin,     // One-cycle round complete
  output logic [6:0]  node_count  // Sum nodes written so far
);

  htree_state_t state;
  logic         rd_pend;    // Child read granted, data not back yet
  logic         in_read;    // In one of the two child read states
  logic [6:0]   child_addr; // Address of the child being handled
  node_t        child_q;    // Child entry as read back

  assign in_read = (state == l1_read) || (state == l2_read);

  // First child during l1_read and null1, second one afterwards
  assign child_addr = ((state == l1_read) || (state == null1)) ?
                      least1.idx[6:0] : least2.idx[6:0];

  always_comb begin
    mem_req      = '0;
    mem_req.addr = child_addr;
    if (build_en) begin
      case (state)
        new_node: begin
          mem_req.req   = 1'b1;
          mem_req.op    = op_write;
          mem_req.addr  = 7'(sum_base) + node_count; // Next free sum slot
          mem_req.wdata = '{active: 1'b1, left: least1, right: least2, freq: sum};
        end
        l1_read, l2_read: begin
          mem_req.req = !rd_pend; // Hold until granted, then wait for data
          mem_req.op  = op_read;
        end
        null1, null2: begin
          mem_req.req          = 1'b1;
          mem_req.op           = op_write;
          mem_req.wdata        = child_q;
          mem_req.wdata.active = 1'b0; // Child is merged now
        end
        default: begin
          mem_req.req = 1'b0; // fin drives nothing
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      state      <= new_node;
      rd_pend    <= 1'b0;
      ht_fin     <= 1'b0;
      node_count <= '0;
    end else begin
      ht_fin <= 1'b0;
      if (!build_en) begin
        state   <= new_node; // Ready for the next round
        rd_pend <= 1'b0;
      end else begin
        case (state)
          new_node: begin
            if (grant) begin
              node_count <= node_count + 7'd1;
              state      <= l1_read;
            end
          end
          l1_read, l2_read: begin
            if (grant) begin
              rd_pend <= 1'b1;
            end
            if (rd_finished) begin
              rd_pend <= 1'b0;
              state   <= (state == l1_read) ? null1 : null2;
            end
          end
          null1: begin
            if (grant) begin
              state <= l2_read;
            end
          end
          null2: begin
            if (grant) begin
              state  <= fin;
              ht_fin <= 1'b1; // High while sitting in fin's first cycle
            end
          end
          default: begin
            state <= fin; // Park until build_en drops
          end
        endcase
      end
    end
  end

  // Latch the child word on its return strobe
  always_ff @(posedge clk) begin
    if (in_read && rd_finished) begin
      child_q <= rdata;
    end
  end

endmodule

// File: rtl/huff_flv.sv
`timescale 1ns/1ps

module huff_flv import huff_pkg::*; #(
  parameter int num_leaves = 64, // Leaf addresses scanned below sum_base
  parameter int depth      = 128 // Memory words, last scanned address is depth-1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        find_en,
  output mem_req_t    mem_req,
  input  logic        grant,
  input  logic        rd_finished,
  input  node_t       rdata,
  output node_id_t    least1,  // Smallest active node
  output node_id_t    least2,  // Second smallest
  output logic [45:0] sum,     // Combined frequency of both
  output logic        flv_done
);

  logic        find_en_q;  // For rising-edge detect
  logic        start_scan;
  logic        issued_all; // Every address has been requested
  logic [6:0]  addr;       // Next address to request
  logic [6:0]  rd_addr;    // Address whose data returns next cycle
  logic        rd_last;    // That read is the final one of the scan
  node_id_t    rd_id;      // Node id formed from rd_addr
  logic        take1;      // Returned node becomes the new smallest
  logic        take2;      // Returned node becomes the second smallest
  logic        l1_valid;
  logic        l2_valid;
  node_id_t    l1_id;
  node_id_t    l2_id;
  logic [45:0] l1_freq;
  logic [45:0] l2_freq;

  assign start_scan = find_en && !find_en_q;

  // Leaf index is its symbol and address, sum index is its address
  assign rd_id = '{is_sum: (rd_addr >= 7'(sum_base)), idx: {1'b0, rd_addr}};

  // Strict compare, so on a tie the lower address already held wins
  assign take1 = rd_finished && rdata.active && (!l1_valid || rdata.freq < l1_freq);
  assign take2 = rd_finished && rdata.active && !take1 &&
                 (!l2_valid || rdata.freq < l2_freq);

  // Back-to-back reads, one per granted cycle
  always_comb begin
    mem_req      = '0;
    mem_req.req  = find_en && !issued_all;
    mem_req.op   = op_read;
    mem_req.addr = addr;
  end

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      find_en_q  <= 1'b0;
      issued_all <= 1'b1; // No scan pending
      addr       <= '0;
      rd_last    <= 1'b0;
      l1_valid   <= 1'b0;
      l2_valid   <= 1'b0;
      flv_done   <= 1'b0;
    end else begin
      find_en_q <= find_en;
      flv_done  <= rd_finished && rd_last; // Last compare lands at the same edge
      if (start_scan) begin
        issued_all <= 1'b0;
        addr       <= '0;
        l1_valid   <= 1'b0; // Results held until here
        l2_valid   <= 1'b0;
      end else begin
        if (grant) begin
          rd_last <= (addr == 7'(depth - 1));
          if (addr == 7'(depth - 1)) begin
            issued_all <= 1'b1;
          end else if (addr == 7'(num_leaves - 1)) begin
            addr <= 7'(sum_base); // Skip unused leaf slots
          end else begin
            addr <= addr + 7'd1;
          end
        end
        if (take1) begin
          l1_valid <= 1'b1;
          l2_valid <= l1_valid; // Old smallest moves down
        end else if (take2) begin
          l2_valid <= 1'b1;
        end
      end
    end
  end

  // Candidate payload
  always_ff @(posedge clk) begin
    if (grant) begin
      rd_addr <= addr;
    end
    if (take1) begin
      l2_id   <= l1_id;
      l2_freq <= l1_freq;
      l1_id   <= rd_id;
      l1_freq <= rdata.freq;
    end else if (take2) begin
      l2_id   <= rd_id;
      l2_freq <= rdata.freq;
    end
  end

  assign least1 = l1_valid ? l1_id : null_id;
  assign least2 = l2_valid ? l2_id : null_id;
  assign sum    = (l1_valid ? l1_freq : 46'd0) + (l2_valid ? l2_freq : 46'd0);

endmodule

// File: rtl/huff_sram_arb.sv
`timescale 1ns/1ps

module huff_sram_arb import huff_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t ht_req,   // Builder, highest priority
  input  mem_req_t flv_req,  // Finder
  input  mem_req_t host_req, // Host, lowest priority
  output mem_req_t mem_req,  // Winner toward the memory
  output logic     ht_grant,
  output logic     flv_grant,
  output logic     host_grant,
  output logic     ht_rd_finished,
  output logic     flv_rd_finished,
  output logic     host_rd_finished
);

  logic [2:0] rd_owner; // One-hot {host, flv, ht} of last cycle's granted read

  // Fixed priority, a lower peer waits while a higher one asks
  always_comb begin
    ht_grant   = ht_req.req;
    flv_grant  = flv_req.req && !ht_req.req;
    host_grant = host_req.req && !ht_req.req && !flv_req.req;

    if (ht_grant) begin
      mem_req = ht_req;
    end else if (flv_grant) begin
      mem_req = flv_req;
    end else if (host_grant) begin
      mem_req = host_req;
    end else begin
      mem_req = '0; // Idle memory cycle
    end
  end

  // Remember who read, the data returns one cycle later
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      rd_owner <= '0;
    end else begin
      rd_owner[0] <= ht_grant && (ht_req.op == op_read);
      rd_owner[1] <= flv_grant && (flv_req.op == op_read);
      rd_owner[2] <= host_grant && (host_req.op == op_read);
    end
  end

  assign ht_rd_finished   = rd_owner[0];
  assign flv_rd_finished  = rd_owner[1];
  assign host_rd_finished = rd_owner[2];

endmodule

// File: rtl/huff_node_sram.sv
`timescale 1ns/1ps

module huff_node_sram import huff_pkg::*; #(
  parameter int depth = 128 // Number of node words
) (
  input  logic     clk,
  input  mem_req_t req,  // Already arbitrated request
  output node_t    rdata // Valid the cycle after a read
);

  node_t mem [depth]; // Node storage, leaves low and sum nodes from sum_base

  // Single port, one access per cycle
  always_ff @(posedge clk) begin
    if (req.req) begin
      if (req.op == op_write) begin
        mem[req.addr] <= req.wdata; // Lands at the granted edge
      end else begin
        rdata <= mem[req.addr];     // One-cycle read latency
      end
    end
  end

  // rdata holds the last read word when no read is issued,
  // so a requester may sample it only on its finished strobe

endmodule

// File: rtl/huff_pkg.sv
package huff_pkg;

  localparam int unsigned sum_base = 64; // First sum-node address

  // Node reference, 9 bits
  typedef struct packed {
    logic       is_sum; // Set for sum nodes
    logic [7:0] idx;    // Symbol for a leaf, address for a sum node
  } node_id_t;

  // Marks a missing node
  localparam node_id_t null_id = '{is_sum: 1'b1, idx: 8'h80};

  // One memory word, 65 bits
  typedef struct packed {
    logic        active; // Still waiting to be merged
    node_id_t    left;   // Lower-frequency child
    node_id_t    right;
    logic [45:0] freq;
  } node_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_t;

  // Request from one peer toward the node memory, 74 bits
  typedef struct packed {
    logic       req;
    mem_op_t    op;
    logic [6:0] addr;
    node_t      wdata; // Only meaningful on writes
  } mem_req_t;

  typedef enum logic [1:0] {
    idle,
    find,  // Finder scanning
    build, // Builder merging two nodes
    done   // Single-cycle end of run
  } ctrl_state_t;

  typedef enum logic [2:0] {
    new_node, // Write the sum node
    l1_read,  // Fetch first child
    null1,    // Write back first child inactive
    l2_read,
    null2,
    fin       // Round complete, wait for build_en to drop
  } htree_state_t;

endpackage
